// File: Makefile
TOP = regfile_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f regfile.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q '\*\* PASS \*\*' sim.log || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// File: regfile.f
+incdir+source
source/regfile_pkg.sv
source/write_pipeline.sv
source/phys_ram.sv
source/bypass_select.sv
source/arch_regfile.sv
source/read_port.sv
source/regfile_top.sv
test/regfile_properties.sv
test/regfile_tb.sv

// File: source/arch_regfile.sv
`include "regfile_defs.svh"

module arch_regfile
  import regfile_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       ret_en,
  input  arch_addr_t ret_arch,
  input  data_t      ret_data,
  input  arch_addr_t rd0_arch,
  output data_t      rd0_data,
  input  arch_addr_t rd1_arch,
  output data_t      rd1_data
);

  localparam int DEPTH = 2 ** `REGFILE_ARCH_ADDR_WIDTH;

  logic       cap_en;
  arch_addr_t cap_arch;
  data_t      cap_data;
  data_t      arch_mem [DEPTH];

  // Capture stage
  always_ff @(posedge clk) begin
    if (rst) begin
      cap_en <= 1'b0;
    end else begin
      cap_en <= ret_en;
    end
  end

  always_ff @(posedge clk) begin
    if (ret_en) begin
      cap_arch <= ret_arch;
      cap_data <= ret_data;
    end
  end

  // Committed state, zero out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        arch_mem[i] <= '0;
      end
    end else if (cap_en) begin
      arch_mem[cap_arch] <= cap_data;
    end
  end

  // No bypass from the capture stage
  assign rd0_data = arch_mem[rd0_arch];
  assign rd1_data = arch_mem[rd1_arch];

endmodule

// File: source/bypass_select.sv
`include "regfile_defs.svh"

module bypass_select
  import regfile_pkg::*;
(
  input  phys_addr_t addr,
  input  data_t      ram_data,
  input  wr_en_t     s0_en,
  input  wr_addr_t   s0_addr,
  input  wr_data_t   s0_data,
  input  wr_en_t     s1_en,
  input  wr_addr_t   s1_addr,
  input  wr_data_t   s1_data,
  input  wr_en_t     s2_en,
  input  wr_addr_t   s2_addr,
  input  wr_data_t   s2_data,
  output data_t      data
);

  wr_en_t hit_s0;
  wr_en_t hit_s1;
  wr_en_t hit_s2;

  // Address match per in-flight write
  always_comb begin
    for (int i = 0; i < `REGFILE_WR_PORTS; i++) begin
      hit_s0[i] = s0_en[i] && (s0_addr[i] == addr);
      hit_s1[i] = s1_en[i] && (s1_addr[i] == addr);
      hit_s2[i] = s2_en[i] && (s2_addr[i] == addr);
    end
  end

  // Oldest source first, each later assignment overrides
  always_comb begin
    data = ram_data;
    for (int i = 0; i < `REGFILE_WR_PORTS; i++) begin
      if (hit_s2[i]) begin
        data = s2_data[i];
      end
    end
    for (int i = 0; i < `REGFILE_WR_PORTS; i++) begin
      if (hit_s1[i]) begin
        data = s1_data[i];
      end
    end
    for (int i = 0; i < `REGFILE_WR_PORTS; i++) begin
      if (hit_s0[i]) begin
        data = s0_data[i]; // Same-cycle write is newest
      end
    end
  end

endmodule

// File: source/phys_ram.sv
`include "regfile_defs.svh"

module phys_ram
  import regfile_pkg::*;
(
  input  logic       clk,
  input  wr_en_t     wr_en,
  input  wr_addr_t   wr_addr,
  input  wr_data_t   wr_data,
  input  phys_addr_t rd0_addr,
  output data_t      rd0_data,
  input  phys_addr_t rd1_addr,
  output data_t      rd1_data,
  input  phys_addr_t ret_addr,
  output data_t      ret_data
);

  localparam int DEPTH = 2 ** `REGFILE_PHYS_ADDR_WIDTH;

  data_t mem [DEPTH];

  // Later port applied last so it wins on a shared address
  always_ff @(posedge clk) begin
    for (int i = 0; i < `REGFILE_WR_PORTS; i++) begin
      if (wr_en[i]) begin
        mem[wr_addr[i]] <= wr_data[i];
      end
    end
  end

  assign rd0_data = mem[rd0_addr]; // Operand read 0
  assign rd1_data = mem[rd1_addr]; // Operand read 1
  assign ret_data = mem[ret_addr]; // Retire read

endmodule

// File: source/read_port.sv
module read_port
  import regfile_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  read_en,
  input  logic  const_en,
  input  data_t const_val,
  input  logic  oe,
  input  data_t phys_data,
  input  data_t arch_data,
  output data_t data
);

  data_t src_data;

  // Constant, then physical, then retirement copy
  always_comb begin
    if (const_en) begin
      src_data = const_val;
    end else if (oe) begin
      src_data = phys_data;
    end else begin
      src_data = arch_data;
    end
  end

  // Held while read_en is low
  always_ff @(posedge clk) begin
    if (rst) begin
      data <= '0;
    end else if (read_en) begin
      data <= src_data;
    end
  end

endmodule

// File: source/regfile_defs.svh
`ifndef REGFILE_DEFS_SVH
`define REGFILE_DEFS_SVH

// Register value width
`define REGFILE_DATA_WIDTH 32

// 128 physical registers
`define REGFILE_PHYS_ADDR_WIDTH 7

// 32 architectural registers
`define REGFILE_ARCH_ADDR_WIDTH 5

// Port counts
`define REGFILE_WR_PORTS 2
`define REGFILE_RD_PORTS 2

`endif

// File: source/regfile_pkg.sv
`include "regfile_defs.svh"

package regfile_pkg;

  typedef logic [`REGFILE_DATA_WIDTH-1:0] data_t;
  typedef logic [`REGFILE_PHYS_ADDR_WIDTH-1:0] phys_addr_t;
  typedef logic [`REGFILE_ARCH_ADDR_WIDTH-1:0] arch_addr_t;

  // One entry per write port, port 1 in the upper slot
  typedef logic [`REGFILE_WR_PORTS-1:0] wr_en_t;
  typedef phys_addr_t [`REGFILE_WR_PORTS-1:0] wr_addr_t;
  typedef data_t [`REGFILE_WR_PORTS-1:0] wr_data_t;

endpackage

// File: source/regfile_top.sv
`include "regfile_defs.svh"

module regfile_top
  import regfile_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  wr_en_t     wr_en,
  input  wr_addr_t   wr_addr,
  input  wr_data_t   wr_data,
  input  logic       read_en,
  input  phys_addr_t rd0_addr,
  input  arch_addr_t rd0_arch,
  input  logic       rd0_oe,
  input  logic       rd0_const_en,
  input  data_t      rd0_const,
  output data_t      rd0_data,
  input  phys_addr_t rd1_addr,
  input  arch_addr_t rd1_arch,
  input  logic       rd1_oe,
  input  logic       rd1_const_en,
  input  data_t      rd1_const,
  output data_t      rd1_data,
  input  logic       ret_en,
  input  phys_addr_t ret_phys,
  input  arch_addr_t ret_arch
);

  wr_en_t   s1_en;
  wr_addr_t s1_addr;
  wr_data_t s1_data;
  wr_en_t   s2_en;
  wr_addr_t s2_addr;
  wr_data_t s2_data;

  data_t ram_rd [`REGFILE_RD_PORTS];  // Raw array reads
  data_t fwd_rd [`REGFILE_RD_PORTS];  // After forwarding
  data_t arch_rd [`REGFILE_RD_PORTS];
  data_t ram_ret;
  data_t fwd_ret;

  write_pipeline u_write_pipeline (
    .clk, .rst, .wr_en, .wr_addr, .wr_data,
    .s1_en, .s1_addr, .s1_data,
    .s2_en, .s2_addr, .s2_data
  );

  phys_ram u_phys_ram (
    .clk, .wr_en(s2_en), .wr_addr(s2_addr), .wr_data(s2_data),
    .rd0_addr, .rd0_data(ram_rd[0]),
    .rd1_addr, .rd1_data(ram_rd[1]),
    .ret_addr(ret_phys), .ret_data(ram_ret)
  );

  bypass_select rd0_bypass (
    .addr(rd0_addr), .ram_data(ram_rd[0]),
    .s0_en(wr_en), .s0_addr(wr_addr), .s0_data(wr_data),
    .s1_en, .s1_addr, .s1_data, .s2_en, .s2_addr, .s2_data,
    .data(fwd_rd[0])
  );

  bypass_select rd1_bypass (
    .addr(rd1_addr), .ram_data(ram_rd[1]),
    .s0_en(wr_en), .s0_addr(wr_addr), .s0_data(wr_data),
    .s1_en, .s1_addr, .s1_data, .s2_en, .s2_addr, .s2_data,
    .data(fwd_rd[1])
  );

  // Retire sees the same newest value as a read
  bypass_select ret_bypass (
    .addr(ret_phys), .ram_data(ram_ret),
    .s0_en(wr_en), .s0_addr(wr_addr), .s0_data(wr_data),
    .s1_en, .s1_addr, .s1_data, .s2_en, .s2_addr, .s2_data,
    .data(fwd_ret)
  );

  arch_regfile u_arch_regfile (
    .clk, .rst, .ret_en, .ret_arch, .ret_data(fwd_ret),
    .rd0_arch, .rd0_data(arch_rd[0]),
    .rd1_arch, .rd1_data(arch_rd[1])
  );

  read_port u_read_port0 (
    .clk, .rst, .read_en, .const_en(rd0_const_en), .const_val(rd0_const),
    .oe(rd0_oe), .phys_data(fwd_rd[0]), .arch_data(arch_rd[0]), .data(rd0_data)
  );

  read_port u_read_port1 (
    .clk, .rst, .read_en, .const_en(rd1_const_en), .const_val(rd1_const),
    .oe(rd1_oe), .phys_data(fwd_rd[1]), .arch_data(arch_rd[1]), .data(rd1_data)
  );

endmodule

// File: source/write_pipeline.sv
`include "regfile_defs.svh"

module write_pipeline
  import regfile_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  wr_en_t   wr_en,
  input  wr_addr_t wr_addr,
  input  wr_data_t wr_data,
  output wr_en_t   s1_en,
  output wr_addr_t s1_addr,
  output wr_data_t s1_data,
  output wr_en_t   s2_en,
  output wr_addr_t s2_addr,
  output wr_data_t s2_data
);

  // Strobes move every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_en <= '0;
      s2_en <= '0;
    end else begin
      s1_en <= wr_en;
      s2_en <= s1_en;
    end
  end

  // Stage one payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < `REGFILE_WR_PORTS; i++) begin
      if (wr_en[i]) begin
        s1_addr[i] <= wr_addr[i];
        s1_data[i] <= wr_data[i];
      end
    end
  end

  // Stage two payload, feeds the array write
  always_ff @(posedge clk) begin
    for (int i = 0; i < `REGFILE_WR_PORTS; i++) begin
      if (s1_en[i]) begin
        s2_addr[i] <= s1_addr[i];
        s2_data[i] <= s1_data[i];
      end
    end
  end

endmodule

// File: test/regfile_properties.sv
module regfile_properties
  import regfile_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input wr_en_t     wr_en,
  input wr_addr_t   wr_addr,
  input logic       read_en,
  input phys_addr_t rd0_addr,
  input logic       rd0_oe,
  input logic       rd0_const_en,
  input data_t      rd0_data,
  input phys_addr_t rd1_addr,
  input logic       rd1_oe,
  input logic       rd1_const_en,
  input data_t      rd1_data
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PHYS_REGS = 2 ** $bits(phys_addr_t);

  logic [PHYS_REGS-1:0] written; // Registers written since reset
  logic rd0_known;
  logic rd1_known;

  always_ff @(posedge clk) begin
    if (rst) begin
      written <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (wr_en[i]) begin
          written[wr_addr[i]] <= 1'b1;
        end
      end
    end
  end

  // Same-cycle writes count through forwarding
  assign rd0_known = written[rd0_addr] || (wr_en[0] && wr_addr[0] == rd0_addr) ||
                     (wr_en[1] && wr_addr[1] == rd0_addr);
  assign rd1_known = written[rd1_addr] || (wr_en[0] && wr_addr[0] == rd1_addr) ||
                     (wr_en[1] && wr_addr[1] == rd1_addr);

  hold_when_idle: assert property (@(posedge clk) disable iff (rst)
    !read_en |=> $stable(rd0_data) && $stable(rd1_data))
    else $error("read data changed while read_en was low");

  rd0_defined: assert property (@(posedge clk) disable iff (rst)
    read_en && !rd0_const_en && rd0_oe && rd0_known |=> !$isunknown(rd0_data))
    else $error("rd0_data unknown after a read of a written register");

  rd1_defined: assert property (@(posedge clk) disable iff (rst)
    read_en && !rd1_const_en && rd1_oe && rd1_known |=> !$isunknown(rd1_data))
    else $error("rd1_data unknown after a read of a written register");

  zero_after_reset: assert property (@(posedge clk)
    rst |=> (rd0_data == '0) && (rd1_data == '0))
    else $error("read data not zero after reset");

endmodule

bind regfile_top regfile_properties u_properties (
  .clk(clk),
  .rst(rst),
  .wr_en(wr_en),
  .wr_addr(wr_addr),
  .read_en(read_en),
  .rd0_addr(rd0_addr),
  .rd0_oe(rd0_oe),
  .rd0_const_en(rd0_const_en),
  .rd0_data(rd0_data),
  .rd1_addr(rd1_addr),
  .rd1_oe(rd1_oe),
  .rd1_const_en(rd1_const_en),
  .rd1_data(rd1_data)
);

// File: test/regfile_tb.sv
module regfile_tb
  import regfile_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED = 25836;
  localparam int PHYS_REGS = 2 ** $bits(phys_addr_t);
  localparam int ARCH_REGS = 2 ** $bits(arch_addr_t);
  localparam int RESET_CYCLES = 10;
  localparam int FILL_CYCLES = PHYS_REGS / 2; // Two writes per cycle
  localparam int RANDOM_CYCLES = 3000;
  // Reset, fill, readback and random cycles plus margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic       clk;
  logic       rst;
  wr_en_t     wr_en;
  wr_addr_t   wr_addr;
  wr_data_t   wr_data;
  logic       read_en;
  phys_addr_t rd0_addr;
  arch_addr_t rd0_arch;
  logic       rd0_oe;
  logic       rd0_const_en;
  data_t      rd0_const;
  data_t      rd0_data;
  phys_addr_t rd1_addr;
  arch_addr_t rd1_arch;
  logic       rd1_oe;
  logic       rd1_const_en;
  data_t      rd1_const;
  data_t      rd1_data;
  logic       ret_en;
  phys_addr_t ret_phys;
  arch_addr_t ret_arch;

  data_t      phys_m [PHYS_REGS]; // Written at once, newest value
  data_t      arch_m [ARCH_REGS];
  logic       ret_d1_en;
  arch_addr_t ret_d1_arch;
  data_t      ret_d1_data;
  logic       ret_d2_en;
  arch_addr_t ret_d2_arch;
  data_t      ret_d2_data;
  data_t      exp0;
  data_t      exp1;
  int         cycles;

  regfile_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $fatal(1, "run stopped by the cycle limit");
  end

  task automatic check_value(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  // Half the picks land in a small window to hit in-flight writes
  function automatic phys_addr_t pick_phys();
    if ($urandom_range(0, 1) == 0) begin
      return phys_addr_t'($urandom_range(0, 7));
    end
    return phys_addr_t'($urandom_range(0, PHYS_REGS - 1));
  endfunction

  function automatic arch_addr_t pick_arch();
    if ($urandom_range(0, 1) == 0) begin
      return arch_addr_t'($urandom_range(0, 3));
    end
    return arch_addr_t'($urandom_range(0, ARCH_REGS - 1));
  endfunction

  function automatic data_t source_value(input logic const_en, input data_t const_val,
                                         input logic oe, input phys_addr_t addr,
                                         input arch_addr_t arch);
    if (const_en) begin
      return const_val;
    end
    if (oe) begin
      return phys_m[addr];
    end
    return arch_m[arch];
  endfunction

  task automatic clear_inputs();
    wr_en = '0;
    wr_addr = '0;
    wr_data = '0;
    read_en = 1'b0;
    rd0_addr = '0;
    rd0_arch = '0;
    rd0_oe = 1'b0;
    rd0_const_en = 1'b0;
    rd0_const = '0;
    rd1_addr = '0;
    rd1_arch = '0;
    rd1_oe = 1'b0;
    rd1_const_en = 1'b0;
    rd1_const = '0;
    ret_en = 1'b0;
    ret_phys = '0;
    ret_arch = '0;
  endtask

  task automatic drive_random();
    wr_en = wr_en_t'($urandom_range(0, 3));
    for (int p = 0; p < 2; p++) begin
      wr_addr[p] = pick_phys();
      wr_data[p] = $urandom();
    end
    read_en = ($urandom_range(0, 3) != 0);
    rd0_const_en = ($urandom_range(0, 5) == 0);
    rd0_oe = ($urandom_range(0, 2) != 0);
    rd0_const = $urandom();
    rd0_addr = pick_phys();
    rd0_arch = pick_arch();
    rd1_const_en = ($urandom_range(0, 5) == 0);
    rd1_oe = ($urandom_range(0, 2) != 0);
    rd1_const = $urandom();
    rd1_addr = pick_phys();
    rd1_arch = pick_arch();
    ret_en = ($urandom_range(0, 3) == 0);
    ret_phys = pick_phys();
    ret_arch = pick_arch();
  endtask

  // Apply this cycle's inputs to the model
  task automatic update_model();
    for (int p = 0; p < 2; p++) begin
      if (wr_en[p]) begin
        phys_m[wr_addr[p]] = wr_data[p]; // Port 1 last
      end
    end
    if (ret_en) begin
      ret_d1_en = 1'b1;
      ret_d1_arch = ret_arch;
      ret_d1_data = phys_m[ret_phys];
    end
    if (read_en) begin
      exp0 = source_value(rd0_const_en, rd0_const, rd0_oe, rd0_addr, rd0_arch);
      exp1 = source_value(rd1_const_en, rd1_const, rd1_oe, rd1_addr, rd1_arch);
    end
  endtask

  // Clock edge, output check, then the retire delay line moves on
  task automatic next_cycle();
    @(posedge clk);
    #1;
    check_value("rd0_data", rd0_data, exp0);
    check_value("rd1_data", rd1_data, exp1);
    if (ret_d2_en) begin
      arch_m[ret_d2_arch] = ret_d2_data;
    end
    ret_d2_en = ret_d1_en;
    ret_d2_arch = ret_d1_arch;
    ret_d2_data = ret_d1_data;
    ret_d1_en = 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    clear_inputs();
    rst = 1'b1;
    for (int i = 0; i < ARCH_REGS; i++) begin
      arch_m[i] = '0;
    end
    ret_d1_en = 1'b0;
    ret_d2_en = 1'b0;
    exp0 = '0;
    exp1 = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    // Fill while reading the zeroed retirement file
    for (int i = 0; i < FILL_CYCLES; i++) begin
      clear_inputs();
      wr_en = 2'b11;
      wr_addr[0] = phys_addr_t'(2 * i);
      wr_addr[1] = phys_addr_t'(2 * i + 1);
      wr_data[0] = $urandom();
      wr_data[1] = $urandom();
      read_en = 1'b1;
      rd0_arch = pick_arch();
      rd1_arch = pick_arch();
      update_model();
      next_cycle();
    end

    for (int i = 0; i < FILL_CYCLES; i++) begin
      clear_inputs();
      read_en = 1'b1;
      rd0_oe = 1'b1;
      rd1_oe = 1'b1;
      rd0_addr = phys_addr_t'(2 * i);
      rd1_addr = phys_addr_t'(2 * i + 1);
      update_model();
      next_cycle();
    end

    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      drive_random();
      update_model();
      next_cycle();
    end

    $display("** PASS **");
    $finish;
  end

endmodule
